// ==== cache_pkg.sv ====
package cache_pkg;

    // byte address width
    localparam int ADDR_W = 32;

    // byte offset inside one line, 32 bytes per line
    localparam int OFFSET_W = 5;

    // one fetch word, one instruction
    localparam int WORD_W = 32;

    // full line as the memory port delivers it
    localparam int LINE_W = 256;

    // associativity
    localparam int NUM_WAYS = 4;

    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [WORD_W-1:0] word_t;

    typedef logic [LINE_W-1:0] line_t;

    // way number, 0..3
    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

    // one bit per way, one-hot or one-cold
    typedef logic [NUM_WAYS-1:0] way_mask_t;

endpackage : cache_pkg

// ==== way_sram.sv ====
`timescale 1ns/100ps

module way_sram #(
    parameter int  DEPTH_W = 4,
    parameter type entry_t = logic [31:0]
) (
    input  logic               clk,
    input  logic               we_i,
    input  logic [DEPTH_W-1:0] addr_i,
    input  entry_t             wdata_i,
    output entry_t             rdata_o
);

    // one entry per set, tag or full line depending on entry_t
    entry_t mem [2**DEPTH_W];

    // asynchronous read port
    // hit logic needs the entry in the same cycle as the address
    assign rdata_o = mem[addr_i];

    // single write port, rising edge
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

endmodule : way_sram

// ==== valid_bits.sv ====
`timescale 1ns/100ps

module valid_bits #(
    parameter int INDEX_W = 4
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic [INDEX_W-1:0]   set_i,
    input  cache_pkg::way_mask_t set_way_i,
    output cache_pkg::way_mask_t valid_o
);

    // one flag per way, per set
    cache_pkg::way_mask_t valid_q [2**INDEX_W];

    // flags of the addressed set, read without delay
    assign valid_o = valid_q[set_i];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // every set empty, first access always misses
            for (int s = 0; s < 2**INDEX_W; s++) begin
                valid_q[s] <= '0;
            end
        end else begin
            // mask is zero outside a fill
            // no invalidate path, icache only ever fills
            valid_q[set_i] <= valid_q[set_i] | set_way_i;
        end
    end

endmodule : valid_bits

// ==== plru_tree.sv ====
`timescale 1ns/100ps

module plru_tree #(
    parameter int INDEX_W = 4
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic [INDEX_W-1:0] set_i,
    input  logic               touch_i,
    input  cache_pkg::way_t    touch_way_i,
    input  logic               fill_i,
    output cache_pkg::way_t    victim_o
);

    // bit 0: root, 0 = victim in left pair (ways 0/1), 1 = right pair (ways 2/3)
    // bit 1: left pair, 0 = way 0, 1 = way 1
    // bit 2: right pair, 0 = way 2, 1 = way 3
    logic [2:0] tree_q [2**INDEX_W];

    logic [2:0]      tree;
    cache_pkg::way_t use_way;

    assign tree = tree_q[set_i];

    // follow the bits down to the victim
    assign victim_o = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};

    // fill consumes the victim, touch names the hit way
    assign use_way = fill_i ? victim_o : touch_way_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // all zero, way 0 goes first
            for (int s = 0; s < 2**INDEX_W; s++) begin
                tree_q[s] <= '0;
            end
        end else if (fill_i || touch_i) begin
            // root points to the other pair
            tree_q[set_i][0] <= ~use_way[1];
            // pair bit points to the sibling way
            if (use_way[1]) begin
                tree_q[set_i][2] <= ~use_way[0];
            end else begin
                tree_q[set_i][1] <= ~use_way[0];
            end
        end
    end

endmodule : plru_tree

// ==== icache_datapath.sv ====
`timescale 1ns/100ps

module icache_datapath #(
    parameter int INDEX_W = 4
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  cache_pkg::addr_t cpu_addr_i,
    output cache_pkg::word_t cpu_rdata_o,
    output logic             hit_o,
    output cache_pkg::addr_t mem_addr_o,
    input  cache_pkg::line_t mem_rdata_i,
    input  logic             fill_we_i,
    input  logic             plru_touch_i
);

    // tag gets whatever the index and offset leave over
    localparam int TAG_W  = cache_pkg::ADDR_W - INDEX_W - cache_pkg::OFFSET_W;
    // byte-in-word bits, then word-in-line bits
    localparam int BYTE_W = $clog2(cache_pkg::WORD_W / 8);
    localparam int WSEL_W = cache_pkg::OFFSET_W - BYTE_W;

    typedef logic [TAG_W-1:0] tag_t;

    tag_t                 tag;
    logic [INDEX_W-1:0]   set;
    logic [WSEL_W-1:0]    word_sel;

    tag_t                 tag_rd  [cache_pkg::NUM_WAYS];
    cache_pkg::line_t     line_rd [cache_pkg::NUM_WAYS];
    cache_pkg::way_mask_t valid;
    cache_pkg::way_mask_t hit_map;
    cache_pkg::way_t      hit_way;
    cache_pkg::way_t      victim;
    cache_pkg::way_mask_t fill_map;
    cache_pkg::line_t     hit_line;

    // address split: tag | set | word | byte
    assign tag      = cpu_addr_i[cache_pkg::ADDR_W-1 -: TAG_W];
    assign set      = cpu_addr_i[cache_pkg::OFFSET_W +: INDEX_W];
    assign word_sel = cpu_addr_i[BYTE_W +: WSEL_W];

    // line-aligned request, offset dropped
    assign mem_addr_o = {cpu_addr_i[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W],
                         {cache_pkg::OFFSET_W{1'b0}}};

    // one-hot write enable of the victim way, only during the fill edge
    assign fill_map = fill_we_i ? cache_pkg::way_mask_t'(1) << victim : '0;

    generate
        for (genvar w = 0; w < cache_pkg::NUM_WAYS; w++) begin : g_way
            way_sram #(.DEPTH_W(INDEX_W), .entry_t(tag_t)) u_tag (
                .clk     (clk),
                .we_i    (fill_map[w]),
                .addr_i  (set),
                .wdata_i (tag),
                .rdata_o (tag_rd[w])
            );

            way_sram #(.DEPTH_W(INDEX_W), .entry_t(cache_pkg::line_t)) u_data (
                .clk     (clk),
                .we_i    (fill_map[w]),
                .addr_i  (set),
                .wdata_i (mem_rdata_i),
                .rdata_o (line_rd[w])
            );

            // way hits only when valid and the stored tag matches
            assign hit_map[w] = valid[w] && (tag_rd[w] == tag);
        end
    endgenerate

    // valid bit set on the same edge as tag and data
    valid_bits #(.INDEX_W(INDEX_W)) u_valid (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .set_i     (set),
        .set_way_i (fill_map),
        .valid_o   (valid)
    );

    plru_tree #(.INDEX_W(INDEX_W)) u_plru (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .set_i       (set),
        .touch_i     (plru_touch_i),
        .touch_way_i (hit_way),
        .fill_i      (fill_we_i),
        .victim_o    (victim)
    );

    // hit map to way number
    // at most one bit set, a tag lives in one way only
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            if (hit_map[w]) begin
                hit_way = cache_pkg::way_t'(w);
            end
        end
    end

    assign hit_o    = |hit_map;
    assign hit_line = line_rd[hit_way];

    // word at the request offset
    assign cpu_rdata_o = hit_line[word_sel*cache_pkg::WORD_W +: cache_pkg::WORD_W];

endmodule : icache_datapath

// ==== icache_control.sv ====
`timescale 1ns/100ps

module icache_control (
    input  logic clk,
    input  logic arst_n_i,
    input  logic cpu_read_i,
    input  logic hit_i,
    output logic cpu_resp_o,
    output logic mem_read_o,
    input  logic mem_resp_i,
    output logic fill_we_o,
    output logic plru_touch_o
);

    typedef enum logic {
        COMPARE,
        FETCH
    } state_t;

    state_t state_q;
    state_t state_d;

    // next state
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            COMPARE: begin
                // miss, go get the line
                if (cpu_read_i && !hit_i) begin
                    state_d = FETCH;
                end
            end
            FETCH: begin
                // line written at this edge, request retried as a hit
                if (mem_resp_i) begin
                    state_d = COMPARE;
                end
            end
            default: state_d = COMPARE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= COMPARE;
        end else begin
            state_q <= state_d;
        end
    end

    // strobes
    always_comb begin
        cpu_resp_o   = 1'b0;
        plru_touch_o = 1'b0;
        mem_read_o   = 1'b0;
        fill_we_o    = 1'b0;
        unique case (state_q)
            COMPARE: begin
                // hit answered in the same cycle
                cpu_resp_o   = cpu_read_i && hit_i;
                plru_touch_o = cpu_read_i && hit_i;
            end
            FETCH: begin
                // held until memory answers
                mem_read_o = 1'b1;
                fill_we_o  = mem_resp_i;
            end
            default: ;
        endcase
    end

endmodule : icache_control

// ==== icache_top.sv ====
`timescale 1ns/100ps

module icache_top #(
    parameter int INDEX_W = 4
) (
    input  logic             clk,
    input  logic             arst_n_i,
    // fetch unit
    input  logic             cpu_read_i,
    input  cache_pkg::addr_t cpu_addr_i,
    output cache_pkg::word_t cpu_rdata_o,
    output logic             cpu_resp_o,
    // line-wide memory port
    output logic             mem_read_o,
    output cache_pkg::addr_t mem_addr_o,
    input  cache_pkg::line_t mem_rdata_i,
    input  logic             mem_resp_i
);

    // control <-> datapath
    logic hit;
    logic fill_we;
    logic plru_touch;

    icache_control u_control (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .cpu_read_i   (cpu_read_i),
        .hit_i        (hit),
        .cpu_resp_o   (cpu_resp_o),
        .mem_read_o   (mem_read_o),
        .mem_resp_i   (mem_resp_i),
        .fill_we_o    (fill_we),
        .plru_touch_o (plru_touch)
    );

    // index width set here for the whole tree
    icache_datapath #(.INDEX_W(INDEX_W)) u_datapath (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_rdata_o  (cpu_rdata_o),
        .hit_o        (hit),
        .mem_addr_o   (mem_addr_o),
        .mem_rdata_i  (mem_rdata_i),
        .fill_we_i    (fill_we),
        .plru_touch_i (plru_touch)
    );

endmodule : icache_top

// ==== icache_checker.sv ====
`timescale 1ns/100ps

module icache_checker (
    input logic             clk,
    input logic             arst_n_i,
    input logic             cpu_read_i,
    input logic             cpu_resp_o,
    input logic             mem_read_o,
    input cache_pkg::addr_t mem_addr_o,
    input logic             mem_resp_i
);

    // line request held with a steady address until memory answers
    a_mem_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_read_o && !mem_resp_i |=> mem_read_o && $stable(mem_addr_o))
        else $error("mem_read_o or mem_addr_o changed before mem_resp_i");

    // no answer without a request
    a_resp_req: assert property (@(posedge clk) disable iff (!arst_n_i)
        cpu_resp_o |-> cpu_read_i)
        else $error("cpu_resp_o without cpu_read_i");

    // hit answer and line fetch exclude each other
    a_resp_fetch: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(cpu_resp_o && mem_read_o))
        else $error("cpu_resp_o and mem_read_o high together");

    // memory only sees whole lines
    a_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_read_o |-> mem_addr_o[cache_pkg::OFFSET_W-1:0] == '0)
        else $error("mem_addr_o not line aligned");

endmodule : icache_checker

bind icache_top icache_checker u_checker (.*);

// ==== icache_tb.sv ====
`timescale 1ns/100ps

module icache_tb;

    localparam int INDEX_W  = 4;
    localparam int NUM_SETS = 2**INDEX_W;
    localparam int TAG_W    = cache_pkg::ADDR_W - INDEX_W - cache_pkg::OFFSET_W;
    localparam int WORDS    = cache_pkg::LINE_W / cache_pkg::WORD_W;

    logic             clk = 1'b0;
    logic             arst_n_i;
    logic             cpu_read_i;
    cache_pkg::addr_t cpu_addr_i;
    cache_pkg::word_t cpu_rdata_o;
    logic             cpu_resp_o;
    logic             mem_read_o;
    cache_pkg::addr_t mem_addr_o;
    cache_pkg::line_t mem_rdata_i;
    logic             mem_resp_i;

    // memory contents made up on first use
    cache_pkg::line_t mem_model [cache_pkg::addr_t];
    int               mem_wait = -1;
    // reference copy of tags, valid flags and tree bits
    logic [TAG_W-1:0] ref_tag   [NUM_SETS][cache_pkg::NUM_WAYS];
    bit               ref_valid [NUM_SETS][cache_pkg::NUM_WAYS];
    bit               ref_root  [NUM_SETS];
    bit               ref_left  [NUM_SETS];
    bit               ref_right [NUM_SETS];
    cache_pkg::addr_t last_evict;

    icache_top #(.INDEX_W(INDEX_W)) UUT (.*);

    always #50 clk = ~clk;

    // line memory answering 0 to 5 cycles after the request is seen
    always @(negedge clk) begin
        if (mem_resp_i) begin
            mem_resp_i = 1'b0;
        end else if (mem_read_o) begin
            if (mem_wait < 0) begin
                mem_wait = $urandom_range(5, 0);
            end
            if (mem_wait == 0) begin
                mem_rdata_i = model_line(mem_addr_o);
                mem_resp_i  = 1'b1;
            end
            mem_wait--;
        end
    end

    function automatic cache_pkg::line_t model_line(input cache_pkg::addr_t line_addr);
        cache_pkg::line_t line;
        if (!mem_model.exists(line_addr)) begin
            for (int i = 0; i < WORDS; i++) begin
                line[i*cache_pkg::WORD_W +: cache_pkg::WORD_W] = $urandom;
            end
            mem_model[line_addr] = line;
        end
        return mem_model[line_addr];
    endfunction

    // a used way pushes the tree bits on its path toward the other side
    function automatic void plru_use(input int s, input int w);
        ref_root[s] = (w < 2);
        if (w < 2) begin
            ref_left[s] = (w == 0);
        end else begin
            ref_right[s] = (w == 2);
        end
    endfunction

    // returns 1 when the access should miss and updates the model
    function automatic bit model_access(input cache_pkg::addr_t addr);
        int               s;
        int               way;
        logic [TAG_W-1:0] t;
        s   = int'(addr[cache_pkg::OFFSET_W +: INDEX_W]);
        t   = addr[cache_pkg::ADDR_W-1 -: TAG_W];
        way = -1;
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            if (ref_valid[s][w] && ref_tag[s][w] == t) begin
                way = w;
            end
        end
        if (way >= 0) begin
            plru_use(s, way);
            return 1'b0;
        end
        way = ref_root[s] ? 2 + int'(ref_right[s]) : int'(ref_left[s]);
        if (ref_valid[s][way]) begin
            last_evict = {ref_tag[s][way], INDEX_W'(s), {cache_pkg::OFFSET_W{1'b0}}};
        end
        ref_tag[s][way]   = t;
        ref_valid[s][way] = 1'b1;
        plru_use(s, way);
        return 1'b1;
    endfunction

    task automatic stop_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input cache_pkg::word_t got,
                              input cache_pkg::word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input cache_pkg::addr_t got,
                              input cache_pkg::addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // one fetch checked against the model and the memory line
    task automatic fetch(input cache_pkg::addr_t addr);
        bit               exp_miss;
        bit               missed;
        bit               filled;
        int               cycles;
        cache_pkg::addr_t line_addr;
        cache_pkg::line_t line;
        line_addr = addr & ~cache_pkg::addr_t'(2**cache_pkg::OFFSET_W - 1);
        exp_miss  = model_access(addr);
        missed    = 1'b0;
        filled    = 1'b0;
        cycles    = 0;
        @(negedge clk);
        cpu_read_i = 1'b1;
        cpu_addr_i = addr;
        // sample just before the rising edge
        #40;
        while (!cpu_resp_o) begin
            // answer due in the cycle after the fill
            if (filled) begin
                $display("no cpu_resp_o in the cycle after the fill of line %h", line_addr);
                stop_run();
            end
            if (mem_read_o && !missed) begin
                missed = 1'b1;
                if (cycles != 1) begin
                    $display("mem_read_o for %h rose %0d cycles after the request", addr,
                             cycles);
                    stop_run();
                end
                check_addr("mem_addr_o", mem_addr_o, line_addr);
            end
            filled = mem_read_o && mem_resp_i;
            cycles++;
            if (cycles > 50) begin
                $display("no cpu_resp_o within 50 cycles for address %h", addr);
                stop_run();
            end
            @(negedge clk);
            #40;
        end
        if (missed != exp_miss || (!missed && cycles != 0)) begin
            $display("address %h expected a %s, the cache %s after %0d cycles", addr,
                     exp_miss ? "miss" : "hit", missed ? "missed" : "answered", cycles);
            stop_run();
        end
        line = model_line(line_addr);
        check_word("cpu_rdata_o", cpu_rdata_o,
                   line[addr[cache_pkg::OFFSET_W-1:2]*cache_pkg::WORD_W +: cache_pkg::WORD_W]);
        @(posedge clk);
    endtask

    function automatic cache_pkg::addr_t tag_addr(input int tag, input int set);
        return (tag << (cache_pkg::OFFSET_W + INDEX_W)) | (set << cache_pkg::OFFSET_W);
    endfunction

    task automatic test_cold_miss();
        if (cpu_resp_o !== 1'b0 || mem_read_o !== 1'b0) begin
            $display("cpu_resp_o or mem_read_o not low after reset");
            stop_run();
        end
        fetch(tag_addr(9, 1) | 32'h14);
    endtask

    task automatic test_line_hits();
        for (int i = 0; i < WORDS; i++) begin
            fetch(tag_addr(9, 1) | (i << 2));
        end
        // resident line without a request gets no answer
        @(negedge clk);
        cpu_read_i = 1'b0;
        cpu_addr_i = tag_addr(9, 1);
        #40;
        if (cpu_resp_o !== 1'b0 || mem_read_o !== 1'b0) begin
            $display("cache answered or fetched while cpu_read_i was low");
            stop_run();
        end
        @(posedge clk);
    endtask

    // four tags sharing set 3 all stay resident
    task automatic test_set_fill();
        for (int k = 1; k <= 4; k++) begin
            fetch(tag_addr(k, 3));
        end
        for (int k = 1; k <= 4; k++) begin
            fetch(tag_addr(k, 3));
        end
    endtask

    task automatic test_eviction();
        fetch(tag_addr(3, 3));
        fetch(tag_addr(1, 3));
        fetch(tag_addr(4, 3));
        fetch(tag_addr(2, 3));
        fetch(tag_addr(5, 3));
        // survivors first and then the line the tree gave up
        for (int k = 1; k <= 4; k++) begin
            if (tag_addr(k, 3) != last_evict) begin
                fetch(tag_addr(k, 3));
            end
        end
        fetch(last_evict);
    endtask

    task automatic test_random();
        for (int n = 0; n < 300; n++) begin
            fetch(tag_addr($urandom_range(5, 0), $urandom_range(3, 0))
                  | ($urandom_range(WORDS - 1, 0) << 2));
        end
    endtask

    initial begin
        void'($urandom(32'hebe8_23d6));
        arst_n_i    = 1'b0;
        cpu_read_i  = 1'b0;
        cpu_addr_i  = '0;
        mem_rdata_i = '0;
        mem_resp_i  = 1'b0;
        repeat (2) @(negedge clk);
        arst_n_i = 1'b1;
        test_cold_miss();
        test_line_hits();
        test_set_fill();
        test_eviction();
        test_random();
        @(negedge clk);
        cpu_read_i = 1'b0;
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule : icache_tb

// ==== all.f ====
cache_pkg.sv
way_sram.sv
valid_bits.sv
plru_tree.sv
icache_datapath.sv
icache_control.sv
icache_top.sv
icache_checker.sv
icache_tb.sv

// ==== Makefile ====
SRCS := $(shell cat all.f)

all: run

obj_dir/Vicache_tb: all.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module icache_tb -f all.f -o Vicache_tb

run: obj_dir/Vicache_tb
	./obj_dir/Vicache_tb | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
